/* Makefile */
# Verilator build and run for the ALU execution unit

VERILATOR ?= verilator
TOP       ?= alpu_tb
BUILD_DIR ?= build
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST  := alpu.f

.PHONY: sim clean

# The binary exits non-zero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* alpu.f */
+incdir+source
source/alpu_pkg.sv
source/alpu_decoder.sv
source/alpu_shifter.sv
source/alpu_exec.sv
source/alpu_exec_piped.sv
source/alpu.sv
source/alpu_req_fifo.sv
source/alpu_unit.sv
dv/alpu_tb.sv

/* dv/alpu_tb.sv */
`timescale 1ns/1ps
`include "alpu_config.svh"

module alpu_tb import alpu_pkg::*; ();

  localparam int          W            = `ALPU_REG_WIDTH;
  localparam int          AMT_W        = $clog2(W);
  localparam int          REQ_DEPTH    = `ALPU_REQ_DEPTH;
  localparam int          RSP_CREDITS  = `ALPU_RSP_CREDITS;
  localparam int          N_REQ        = 2000;
  localparam int          RSP_TIMEOUT  = 1000;   // Cycles without any response
  localparam int          DRAIN_TIMEOUT = 200;
  localparam bit [31:0]   SEED         = 32'ha39337bb;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      req_valid_i;
  alpu_req_t req_i;
  logic      req_credit_o;
  logic      rsp_valid_o;
  alpu_rsp_t rsp_o;
  logic      rsp_credit_i;

  alpu_rsp_t                 model_q [$];   // Expected responses in request order
  int                        prod_credits;
  int                        cons_credits;
  int                        pending_ret;   // Responses taken, credit not yet returned
  int                        stall_left;
  int                        stall_rsp;
  int                        n_stalls;
  int                        n_req;
  int                        n_rsp;
  bit                        draining;
  bit                        rsp_seen;
  logic [`ALPU_TAG_WIDTH-1:0] next_tag;
  int                        op_seen [16];
  int                        amt_seen [W];

  always #4 clk = ~clk;

  alpu_unit i_alpu_unit (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .rsp_credit_i (rsp_credit_i)
  );

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  function automatic alpu_rsp_t model_rsp(input alpu_req_t r);
    alpu_rsp_t      e;
    logic [2*W-1:0] dbl;
    int             amt;
    e   = '0;
    e.tag = r.tag;
    amt = int'(r.b[AMT_W-1:0]);
    dbl = {r.a, r.a};                             // Rotates read a window of this
    case (r.op)
      OP_NOT:  e.result = ~r.a;
      OP_AND:  e.result = r.a & r.b;
      OP_OR:   e.result = r.a | r.b;
      OP_XOR:  e.result = r.a ^ r.b;
      OP_NAND: e.result = ~(r.a & r.b);
      OP_NOR:  e.result = ~(r.a | r.b);
      OP_XNOR: e.result = ~(r.a ^ r.b);
      OP_ADD:  {e.cout, e.result} = r.a + r.b + r.cin;
      OP_SUB: begin
        e.result = r.a - r.b;
        e.cout   = (r.a >= r.b);                  // Carry set when no borrow
      end
      OP_RSH:  e.result = r.a >> amt;
      OP_LSH:  e.result = r.a << amt;
      OP_RRO: begin
        dbl      = dbl >> amt;
        e.result = dbl[W-1:0];
      end
      OP_LRO: begin
        dbl      = dbl << amt;
        e.result = dbl[2*W-1:W];
      end
      default: e.err = 1'b1;                      // Result and carry stay zero
    endcase
    return e;
  endfunction

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_rsp(input alpu_rsp_t got, input alpu_rsp_t exp);
    if (got !== exp) begin
      stop_run($sformatf({"CHECK FAILED at %0t: response %0d expected result %h cout %b",
                          " err %b tag %h, got result %h cout %b err %b tag %h"},
                         $time, n_rsp, exp.result, exp.cout, exp.err, exp.tag,
                         got.result, got.cout, got.err, got.tag));
    end
  endtask

  task automatic check_credit(input string what, input int value, input int lo, input int hi);
    if (value < lo || value > hi) begin
      stop_run($sformatf("CHECK FAILED at %0t: %s is %0d, allowed %0d to %0d",
                         $time, what, value, lo, hi));
    end
  endtask

  // ------------------------------------------------------------------
  // Producer, consumer and monitor
  // ------------------------------------------------------------------
  task automatic take_rsp(input alpu_rsp_t got);
    alpu_rsp_t exp;
    if (model_q.size() == 0) begin
      stop_run($sformatf("Response at %0t with no request outstanding", $time));
    end else begin
      check_credit("consumer credits at response", cons_credits, 1, RSP_CREDITS);
      exp = model_q.pop_front();
      check_rsp(got, exp);
      cons_credits--;
      pending_ret++;
      n_rsp++;
      if (stall_left > 0) begin
        stall_rsp++;
        check_credit("responses during stall", stall_rsp, 0, RSP_CREDITS);
      end
    end
  endtask

  task automatic drive_producer();
    alpu_req_t r;
    if (prod_credits > 0 && n_req < N_REQ && $urandom_range(99, 0) < 70) begin
      r.op  = alpu_op_e'(4'($urandom_range(15, 0)));   // Includes illegal 13 to 15
      r.a   = W'($urandom());
      r.b   = W'($urandom());
      r.cin = 1'($urandom());
      r.tag = next_tag;
      next_tag++;
      req_i       = r;
      req_valid_i = 1'b1;
      prod_credits--;
      model_q.push_back(model_rsp(r));
      op_seen[int'(r.op)]++;
      if (r.op inside {OP_RSH, OP_LSH, OP_RRO, OP_LRO}) begin
        amt_seen[int'(r.b[AMT_W-1:0])]++;
      end
      n_req++;
    end else begin
      req_valid_i = 1'b0;
    end
  endtask

  task automatic drive_consumer();
    rsp_credit_i = 1'b0;
    if (stall_left > 0 && !draining) begin
      stall_left--;
    end else if (!draining && $urandom_range(99, 0) < 2) begin
      stall_left = int'($urandom_range(200, 40));    // Long back-pressure
      stall_rsp  = 0;
      n_stalls++;
    end else if (pending_ret > 0 && (draining || $urandom_range(3, 0) != 0)) begin
      rsp_credit_i = 1'b1;
      pending_ret--;
      cons_credits++;
    end
  endtask

  // Outputs are sampled 1 ns after the edge, before new inputs go out
  task automatic step_cycle();
    logic credit_seen;
    @(posedge clk);
    #1;
    credit_seen = req_credit_o;
    rsp_seen    = rsp_valid_o;
    if (rsp_valid_o) begin
      take_rsp(rsp_o);
    end
    drive_producer();
    drive_consumer();
    if (credit_seen) begin   // Usable from the next cycle, the pop happens at this edge
      prod_credits++;
      check_credit("producer credits", prod_credits, 0, REQ_DEPTH);
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------
  initial begin
    int idle;
    int drain_cycles;
    void'($urandom(SEED));
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_credit_i = 1'b0;
    prod_credits = REQ_DEPTH;
    cons_credits = RSP_CREDITS;
    next_tag     = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    idle = 0;
    while (n_rsp < N_REQ) begin
      step_cycle();
      idle = rsp_seen ? 0 : idle + 1;
      if (idle > RSP_TIMEOUT) begin
        stop_run($sformatf("Timeout at %0t: no response for %0d cycles, %0d of %0d received",
                           $time, RSP_TIMEOUT, n_rsp, N_REQ));
      end
    end

    // Return all result credits
    draining     = 1'b1;
    drain_cycles = 0;
    while (pending_ret > 0) begin
      step_cycle();
      drain_cycles++;
      if (drain_cycles > DRAIN_TIMEOUT) begin
        stop_run($sformatf("Timeout at %0t: credits did not settle after the last response",
                           $time));
      end
    end
    repeat (10) step_cycle();   // No stray responses or credits
    check_credit("producer credits after drain", prod_credits, REQ_DEPTH, REQ_DEPTH);

    for (int i = 0; i < 16; i++) begin
      if (op_seen[i] == 0) begin
        stop_run($sformatf("Opcode %0d was never sent", i));
      end
    end
    for (int i = 0; i < W; i++) begin
      if (amt_seen[i] == 0) begin
        stop_run($sformatf("Shift amount %0d was never sent", i));
      end
    end
    if (n_stalls == 0) begin
      stop_run("The consumer never stalled");
    end

    $display("Regression passed");
    $finish;
  end

endmodule

/* source/alpu.sv */
`timescale 1ns/1ps
`include "alpu_config.svh"

module alpu import alpu_pkg::*; #(
  parameter int REG_WIDTH          = `ALPU_REG_WIDTH,
  parameter bit USE_PIPELINED_ALPU = `ALPU_USE_PIPELINED
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      valid_i,
  input  alpu_req_t req_i,
  output logic      valid_o,
  output alpu_rsp_t rsp_o
);

  alpu_ctrl_t                 ctrl;
  logic                       dp_valid;
  logic [`ALPU_TAG_WIDTH-1:0] dp_tag;
  logic                       dp_err;
  logic [REG_WIDTH-1:0]       dp_result;
  logic                       dp_cout;

  alpu_decoder i_alpu_decoder (
    .op_i   (req_i.op),
    .ctrl_o (ctrl)
  );

  // ------------------------------------------------------------------
  // Datapath choice
  // ------------------------------------------------------------------
  if (USE_PIPELINED_ALPU) begin : g_piped
    alpu_exec_piped #(
      .REG_WIDTH(REG_WIDTH)
    ) i_alpu_exec_piped (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .pipe_active_i (1'b1),   // Never stalls, credits cover in-flight ops
      .valid_i       (valid_i),
      .tag_i         (req_i.tag),
      .err_i         (ctrl.illegal),
      .a_i           (req_i.a),
      .b_i           (req_i.b),
      .cin_i         (req_i.cin),
      .ctrl_i        (ctrl),
      .valid_o       (dp_valid),
      .tag_o         (dp_tag),
      .err_o         (dp_err),
      .result_o      (dp_result),
      .cout_o        (dp_cout)
    );
  end else begin : g_single
    alpu_exec #(
      .REG_WIDTH(REG_WIDTH)
    ) i_alpu_exec (
      .a_i      (req_i.a),
      .b_i      (req_i.b),
      .cin_i    (req_i.cin),
      .ctrl_i   (ctrl),
      .result_o (dp_result),
      .cout_o   (dp_cout)
    );
    assign dp_valid = valid_i;
    assign dp_tag   = req_i.tag;
    assign dp_err   = ctrl.illegal;
  end

  // Response register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= dp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dp_valid) begin
      rsp_o.result <= dp_result;
      rsp_o.cout   <= dp_cout;
      rsp_o.err    <= dp_err;
      rsp_o.tag    <= dp_tag;
    end
  end

endmodule

/* source/alpu_config.svh */
`ifndef ALPU_CONFIG_SVH
`define ALPU_CONFIG_SVH

// Operand width in bits, 8 or more
`define ALPU_REG_WIDTH 16

// 1 selects the two-stage datapath, 0 the single-cycle one
`define ALPU_USE_PIPELINED 1

`define ALPU_REQ_DEPTH 4      // Request queue entries, also initial producer credits
`define ALPU_RSP_CREDITS 2    // Result credits granted by the consumer
`define ALPU_TAG_WIDTH 4      // Request tag width

`endif

/* source/alpu_decoder.sv */
`timescale 1ns/1ps

module alpu_decoder import alpu_pkg::*; (
  input  alpu_op_e   op_i,
  output alpu_ctrl_t ctrl_o
);

  always_comb begin
    ctrl_o = '0;
    case (op_i)
      // Logic
      OP_NOT:  ctrl_o.logic_sel = LOGIC_NOT_A;
      OP_AND:  ctrl_o.logic_sel = LOGIC_AND;
      OP_OR:   ctrl_o.logic_sel = LOGIC_OR;
      OP_XOR:  ctrl_o.logic_sel = LOGIC_XOR;
      OP_NAND: begin
        ctrl_o.logic_sel  = LOGIC_AND;
        ctrl_o.invert_out = 1'b1;
      end
      OP_NOR: begin
        ctrl_o.logic_sel  = LOGIC_OR;
        ctrl_o.invert_out = 1'b1;
      end
      OP_XNOR: begin
        ctrl_o.logic_sel  = LOGIC_XOR;
        ctrl_o.invert_out = 1'b1;
      end
      // Arithmetic
      OP_ADD:  ctrl_o.add_en = 1'b1;
      OP_SUB: begin
        ctrl_o.add_en    = 1'b1;
        ctrl_o.invert_b  = 1'b1;   // a + ~b + 1
        ctrl_o.force_cin = 1'b1;
      end
      // Barrel
      OP_RSH:  ctrl_o.shift_en = 1'b1;
      OP_LSH: begin
        ctrl_o.shift_en   = 1'b1;
        ctrl_o.shift_left = 1'b1;
      end
      OP_RRO: begin
        ctrl_o.shift_en     = 1'b1;
        ctrl_o.shift_rotate = 1'b1;
      end
      OP_LRO: begin
        ctrl_o.shift_en     = 1'b1;
        ctrl_o.shift_left   = 1'b1;
        ctrl_o.shift_rotate = 1'b1;
      end
      default: ctrl_o.illegal = 1'b1;   // Opcodes 13 to 15
    endcase
  end

endmodule

/* source/alpu_exec.sv */
`timescale 1ns/1ps

module alpu_exec import alpu_pkg::*; #(
  parameter int REG_WIDTH = 16
) (
  input  logic [REG_WIDTH-1:0] a_i,
  input  logic [REG_WIDTH-1:0] b_i,
  input  logic                 cin_i,
  input  alpu_ctrl_t           ctrl_i,
  output logic [REG_WIDTH-1:0] result_o,
  output logic                 cout_o
);

  logic [REG_WIDTH-1:0] b_eff;
  logic [REG_WIDTH-1:0] logic_res;
  logic [REG_WIDTH-1:0] sum;
  logic [REG_WIDTH-1:0] shift_res;
  logic [REG_WIDTH-1:0] pre_out;
  logic                 add_cin;
  logic                 carry;

  assign b_eff   = ctrl_i.invert_b ? ~b_i : b_i;
  assign add_cin = ctrl_i.force_cin ? 1'b1 : cin_i;   // SUB ignores cin

  assign {carry, sum} = {1'b0, a_i} + {1'b0, b_eff} + {{REG_WIDTH{1'b0}}, add_cin};

  always_comb begin
    case (ctrl_i.logic_sel)
      LOGIC_AND: logic_res = a_i & b_i;
      LOGIC_OR:  logic_res = a_i | b_i;
      LOGIC_XOR: logic_res = a_i ^ b_i;
      default:   logic_res = ~a_i;
    endcase
  end

  alpu_shifter #(
    .REG_WIDTH(REG_WIDTH)
  ) i_alpu_shifter (
    .a_i      (a_i),
    .amount_i (b_i[$clog2(REG_WIDTH)-1:0]),   // Low bits of B
    .left_i   (ctrl_i.shift_left),
    .rotate_i (ctrl_i.shift_rotate),
    .result_o (shift_res)
  );

  // Output select
  always_comb begin
    if (ctrl_i.shift_en) begin
      pre_out = shift_res;
    end else if (ctrl_i.add_en) begin
      pre_out = sum;
    end else begin
      pre_out = logic_res;
    end
    result_o = ctrl_i.invert_out ? ~pre_out : pre_out;
    if (ctrl_i.illegal) begin
      result_o = '0;
    end
  end

  assign cout_o = ctrl_i.add_en & carry;   // Only ADD and SUB carry out

endmodule

/* source/alpu_exec_piped.sv */
`timescale 1ns/1ps
`include "alpu_config.svh"

module alpu_exec_piped import alpu_pkg::*; #(
  parameter int REG_WIDTH = `ALPU_REG_WIDTH
) (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       pipe_active_i,
  input  logic                       valid_i,
  input  logic [`ALPU_TAG_WIDTH-1:0] tag_i,
  input  logic                       err_i,
  input  logic [REG_WIDTH-1:0]       a_i,
  input  logic [REG_WIDTH-1:0]       b_i,
  input  logic                       cin_i,
  input  alpu_ctrl_t                 ctrl_i,
  output logic                       valid_o,
  output logic [`ALPU_TAG_WIDTH-1:0] tag_o,
  output logic                       err_o,
  output logic [REG_WIDTH-1:0]       result_o,
  output logic                       cout_o
);

  logic                       valid_q;
  logic [`ALPU_TAG_WIDTH-1:0] tag_q;
  logic                       err_q;
  logic [REG_WIDTH-1:0]       a_q;
  logic [REG_WIDTH-1:0]       b_q;
  logic                       cin_q;
  alpu_ctrl_t                 ctrl_q;

  // ------------------------------------------------------------------
  // First stage registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (pipe_active_i) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_active_i && valid_i) begin   // Payload only moves with a valid op
      tag_q  <= tag_i;
      err_q  <= err_i;
      a_q    <= a_i;
      b_q    <= b_i;
      cin_q  <= cin_i;
      ctrl_q <= ctrl_i;
    end
  end

  // Second stage is the shared datapath
  alpu_exec #(
    .REG_WIDTH(REG_WIDTH)
  ) i_alpu_exec (
    .a_i      (a_q),
    .b_i      (b_q),
    .cin_i    (cin_q),
    .ctrl_i   (ctrl_q),
    .result_o (result_o),
    .cout_o   (cout_o)
  );

  assign valid_o = valid_q;
  assign tag_o   = tag_q;
  assign err_o   = err_q;

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n_i) !$isunknown(valid_o));

endmodule

/* source/alpu_pkg.sv */
`include "alpu_config.svh"

package alpu_pkg;

  // ------------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------------
  typedef enum logic [3:0] {
    OP_NOT  = 4'h0,
    OP_AND  = 4'h1,
    OP_OR   = 4'h2,
    OP_XOR  = 4'h3,
    OP_ADD  = 4'h4,
    OP_SUB  = 4'h5,
    OP_NAND = 4'h6,
    OP_NOR  = 4'h7,
    OP_XNOR = 4'h8,
    OP_RSH  = 4'h9,
    OP_LSH  = 4'ha,
    OP_RRO  = 4'hb,
    OP_LRO  = 4'hc  // 13 to 15 are illegal
  } alpu_op_e;

  typedef enum logic [1:0] {
    LOGIC_AND   = 2'd0,
    LOGIC_OR    = 2'd1,
    LOGIC_XOR   = 2'd2,
    LOGIC_NOT_A = 2'd3
  } alpu_logic_e;

  // ------------------------------------------------------------------
  // Datapath control word
  // ------------------------------------------------------------------
  typedef struct packed {
    logic        invert_b;      // Adder sees ~b
    logic        force_cin;     // Adder carry-in forced to one
    alpu_logic_e logic_sel;
    logic        add_en;        // Adder drives the result
    logic        invert_out;    // Final inversion for NAND, NOR, XNOR
    logic        shift_en;      // Barrel shifter drives the result
    logic        shift_left;
    logic        shift_rotate;
    logic        illegal;       // Zero result, error flag
  } alpu_ctrl_t;

  // ------------------------------------------------------------------
  // Request and response payloads
  // ------------------------------------------------------------------
  typedef struct packed {
    alpu_op_e                   op;
    logic [`ALPU_REG_WIDTH-1:0] a;
    logic [`ALPU_REG_WIDTH-1:0] b;
    logic                       cin;
    logic [`ALPU_TAG_WIDTH-1:0] tag;
  } alpu_req_t;

  typedef struct packed {
    logic [`ALPU_REG_WIDTH-1:0] result;
    logic                       cout;
    logic                       err;
    logic [`ALPU_TAG_WIDTH-1:0] tag;
  } alpu_rsp_t;

endpackage

/* source/alpu_req_fifo.sv */
`timescale 1ns/1ps
`include "alpu_config.svh"

module alpu_req_fifo import alpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  alpu_req_t data_i,
  input  logic      pop_i,
  output alpu_req_t data_o,
  output logic      empty_o
);

  localparam int DEPTH = `ALPU_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  alpu_req_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  // Wraps correctly for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign empty_o = (count == '0);
  assign data_o  = mem[rd_ptr];   // Head is visible the cycle after push

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // ------------------------------------------------------------------
  // Pointers and fill count
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Idle or push with pop
      endcase
    end
  end

  // Producer pushed without a credit
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i) !(push_i && full));

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i) !(pop_i && empty_o));

endmodule

/* source/alpu_shifter.sv */
`timescale 1ns/1ps

module alpu_shifter #(
  parameter int REG_WIDTH = 16
) (
  input  logic [REG_WIDTH-1:0]         a_i,
  input  logic [$clog2(REG_WIDTH)-1:0] amount_i,
  input  logic                         left_i,
  input  logic                         rotate_i,
  output logic [REG_WIDTH-1:0]         result_o
);

  localparam int AMT_W = $clog2(REG_WIDTH);

  // Left moves are done as right moves on the mirrored word
  function automatic logic [REG_WIDTH-1:0] mirror(input logic [REG_WIDTH-1:0] v);
    logic [REG_WIDTH-1:0] r;
    for (int i = 0; i < REG_WIDTH; i++) begin
      r[i] = v[REG_WIDTH-1-i];
    end
    return r;
  endfunction

  logic [AMT_W:0][REG_WIDTH-1:0] stage;

  assign stage[0] = left_i ? mirror(a_i) : a_i;

  // One stage per amount bit, stage i moves by 2**i
  for (genvar i = 0; i < AMT_W; i++) begin : g_stage
    localparam int STEP = 1 << i;
    logic [REG_WIDTH-1:0] moved;

    assign moved = (stage[i] >> STEP) |
                   (rotate_i ? (stage[i] << (REG_WIDTH - STEP)) : '0);   // Wrap-around bits
    assign stage[i+1] = amount_i[i] ? moved : stage[i];
  end

  assign result_o = left_i ? mirror(stage[AMT_W]) : stage[AMT_W];

endmodule

/* source/alpu_unit.sv */
`timescale 1ns/1ps
`include "alpu_config.svh"

module alpu_unit import alpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,

  // Request side, credit based
  input  logic      req_valid_i,
  input  alpu_req_t req_i,
  output logic      req_credit_o,

  // Result side, credit based
  output logic      rsp_valid_o,
  output alpu_rsp_t rsp_o,
  input  logic      rsp_credit_i
);

  localparam int RSP_CREDITS = `ALPU_RSP_CREDITS;
  localparam int CNT_W       = $clog2(RSP_CREDITS + 1);

  alpu_req_t        head_req;
  logic             fifo_empty;
  logic             issue;
  logic [CNT_W-1:0] credit_cnt;

  // ------------------------------------------------------------------
  // Request queue
  // ------------------------------------------------------------------
  alpu_req_fifo i_alpu_req_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .push_i  (req_valid_i),
    .data_i  (req_i),
    .pop_i   (issue),
    .data_o  (head_req),
    .empty_o (fifo_empty)
  );

  // ------------------------------------------------------------------
  // Issue and result credits
  // ------------------------------------------------------------------
  assign issue        = !fifo_empty && (credit_cnt != '0);
  assign req_credit_o = issue;   // Every pop frees one queue entry

  // A credit is spent at issue, so results in flight are always covered
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt <= CNT_W'(RSP_CREDITS);
    end else begin
      case ({issue, rsp_credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  alpu #(
    .REG_WIDTH          (`ALPU_REG_WIDTH),
    .USE_PIPELINED_ALPU (`ALPU_USE_PIPELINED)
  ) i_alpu (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (issue),
    .req_i   (head_req),
    .valid_o (rsp_valid_o),
    .rsp_o   (rsp_o)
  );

  // Consumer returned more credits than it was granted
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n_i) credit_cnt <= CNT_W'(RSP_CREDITS)
  );

endmodule
